/* Bender.yml */
package:
  name: memory_game

dependencies: {}

sources:
  - files:
      - hw/memory_game_pkg.sv
      - hw/button_pulse.sv
      - hw/key_decoder.sv
      - hw/game_fsm.sv
      - hw/tile_board.sv
      - hw/memory_game_top.sv
  - target: test
    files:
      - verification/tb_clock.sv
      - verification/memory_game_tb.sv

/* hw/button_pulse.sv */
`timescale 1ns/1ps

module button_pulse #(
    parameter int DEBOUNCE_LEN = 7
) (
    input  logic clk,
    input  logic rst,
    input  logic btn_i,
    output logic pulse_o
);

    logic [DEBOUNCE_LEN-1:0] shift_q;
    logic                    level;
    logic                    level_q;

    // Stable only after DEBOUNCE_LEN high samples in a row
    assign level = &shift_q;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            shift_q <= '0;
            level_q <= 1'b0;
            pulse_o <= 1'b0;
        end else begin
            shift_q <= {shift_q[DEBOUNCE_LEN-2:0], btn_i};
            level_q <= level;
            // Rising edge of the debounced level
            pulse_o <= level & ~level_q;
        end
    end

endmodule

/* hw/game_fsm.sv */
`timescale 1ns/1ps

module game_fsm (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         start_i,
    input  memory_game_pkg::count_t      pairs_i,
    output memory_game_pkg::game_state_t state_o
);

    memory_game_pkg::game_state_t state_q;
    memory_game_pkg::game_state_t state_d;
    logic                         all_found;

    assign all_found = (pairs_i == memory_game_pkg::count_t'(memory_game_pkg::NUM_PAIRS));

    always_comb begin
        state_d = state_q;
        case (state_q)
            memory_game_pkg::ST_IDLE: begin
                if (start_i) state_d = memory_game_pkg::ST_SHOW;
            end
            memory_game_pkg::ST_SHOW: begin
                if (start_i) state_d = memory_game_pkg::ST_PLAY;
            end
            // Start is ignored while playing
            memory_game_pkg::ST_PLAY: begin
                if (all_found) state_d = memory_game_pkg::ST_FINISH;
            end
            memory_game_pkg::ST_FINISH: begin
                if (start_i) state_d = memory_game_pkg::ST_IDLE;
            end
            default: state_d = memory_game_pkg::ST_IDLE;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state_q <= memory_game_pkg::ST_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    assign state_o = state_q;

endmodule

/* hw/key_decoder.sv */
`timescale 1ns/1ps

module key_decoder (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          code_valid_i,
    input  memory_game_pkg::scan_code_t   code_i,
    output memory_game_pkg::key_event_t   event_o
);

    memory_game_pkg::scan_code_t code_q;
    logic                        code_vld_q;
    memory_game_pkg::key_event_t dec_evt;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            code_vld_q <= 1'b0;
        end else begin
            code_vld_q <= code_valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (code_valid_i) begin
            code_q <= code_i;
        end
    end

    // Lookup against the fixed key table
    always_comb begin
        dec_evt.valid = 1'b0;
        dec_evt.kind  = memory_game_pkg::KEY_NONE;
        dec_evt.tile  = '0;
        if (code_vld_q) begin
            if (code_q == memory_game_pkg::SC_ENTER) begin
                dec_evt.valid = 1'b1;
                dec_evt.kind  = memory_game_pkg::KEY_ENTER;
            end else if (code_q == memory_game_pkg::SC_SHIFT) begin
                dec_evt.valid = 1'b1;
                dec_evt.kind  = memory_game_pkg::KEY_SHIFT;
            end else begin
                for (int i = 0; i < memory_game_pkg::NUM_TILES; i++) begin
                    if (code_q == memory_game_pkg::TILE_KEY_CODES[i]) begin
                        dec_evt.valid = 1'b1;
                        dec_evt.kind  = memory_game_pkg::KEY_TILE;
                        dec_evt.tile  = memory_game_pkg::tile_idx_t'(i);
                    end
                end
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            event_o <= '0;
        end else begin
            event_o <= dec_evt;
        end
    end

endmodule

/* hw/memory_game_pkg.sv */
package memory_game_pkg;

    localparam int NUM_TILES = 16;
    localparam int NUM_PAIRS = 8;

    typedef logic [3:0] tile_idx_t;

    // Bit 8 flags an extended (E0) code
    typedef logic [8:0] scan_code_t;

    // Keys 1 2 3 4 / Q W E R / A S D F / Z X C V map to tiles 0..15
    localparam scan_code_t TILE_KEY_CODES [NUM_TILES] = '{
        9'h016, 9'h01E, 9'h026, 9'h025,
        9'h015, 9'h01D, 9'h024, 9'h02D,
        9'h01C, 9'h01B, 9'h023, 9'h02B,
        9'h01A, 9'h022, 9'h021, 9'h02A
    };

    localparam scan_code_t SC_ENTER = 9'h05A;
    localparam scan_code_t SC_SHIFT = 9'h012;

    typedef enum logic [1:0] {
        KEY_NONE,
        KEY_TILE,
        KEY_ENTER,
        KEY_SHIFT
    } key_kind_t;

    typedef struct packed {
        logic      valid;
        key_kind_t kind;
        tile_idx_t tile;
    } key_event_t;

    typedef enum logic [1:0] {
        ST_IDLE   = 2'd0,
        ST_SHOW   = 2'd1,
        ST_PLAY   = 2'd2,
        ST_FINISH = 2'd3
    } game_state_t;

    // Tiles 0, 2 and 3 start upside down
    localparam logic [NUM_TILES-1:0] INIT_FLIP = 16'h000D;

    typedef struct packed {
        logic open;
        logic matched;
        logic flipped;
    } tile_status_t;

    typedef logic [3:0] count_t;

endpackage

/* hw/memory_game_top.sv */
`timescale 1ns/1ps

module memory_game_top #(
    parameter int DEBOUNCE_LEN = 7
) (
    input  logic                                  clk,
    input  logic                                  rst,
    input  logic                                  start_i,
    input  logic                                  hint_i,
    input  logic                                  scan_valid_i,
    input  memory_game_pkg::scan_code_t           scan_code_i,
    output memory_game_pkg::game_state_t          state_o,
    output memory_game_pkg::tile_status_t [memory_game_pkg::NUM_TILES-1:0] tiles_o,
    output memory_game_pkg::count_t               pairs_o
);

    logic                         start_pulse;
    memory_game_pkg::key_event_t  key_evt;
    memory_game_pkg::game_state_t state;
    memory_game_pkg::count_t      pair_count;

    button_pulse #(
        .DEBOUNCE_LEN(DEBOUNCE_LEN)
    ) u_button (
        .clk    (clk),
        .rst    (rst),
        .btn_i  (start_i),
        .pulse_o(start_pulse)
    );

    key_decoder u_keys (
        .clk         (clk),
        .rst         (rst),
        .code_valid_i(scan_valid_i),
        .code_i      (scan_code_i),
        .event_o     (key_evt)
    );

    game_fsm u_fsm (
        .clk    (clk),
        .rst    (rst),
        .start_i(start_pulse),
        .pairs_i(pair_count),
        .state_o(state)
    );

    tile_board u_board (
        .clk    (clk),
        .rst    (rst),
        .state_i(state),
        .hint_i (hint_i),
        .event_i(key_evt),
        .tiles_o(tiles_o),
        .pairs_o(pair_count)
    );

    assign state_o = state;
    assign pairs_o = pair_count;

endmodule

/* hw/tile_board.sv */
`timescale 1ns/1ps

module tile_board (
    input  logic                                  clk,
    input  logic                                  rst,
    input  memory_game_pkg::game_state_t          state_i,
    input  logic                                  hint_i,
    input  memory_game_pkg::key_event_t           event_i,
    output memory_game_pkg::tile_status_t [memory_game_pkg::NUM_TILES-1:0] tiles_o,
    output memory_game_pkg::count_t               pairs_o
);

    localparam int N = memory_game_pkg::NUM_TILES;

    logic [N-1:0]               open_q;
    logic [N-1:0]               matched_q;
    logic [N-1:0]               flip_q;
    memory_game_pkg::tile_idx_t sel_q;
    logic                       sel_vld_q;
    memory_game_pkg::count_t    pairs_q;

    memory_game_pkg::tile_idx_t key_tile;
    logic                       reload;
    logic                       apply;
    logic                       tile_ok;
    logic                       pair_hit;

    assign key_tile = event_i.tile;
    assign reload   = (state_i == memory_game_pkg::ST_IDLE) ||
                      (state_i == memory_game_pkg::ST_SHOW);
    assign apply    = event_i.valid && !hint_i && (state_i == memory_game_pkg::ST_PLAY);

    // Key tile must be unmatched and not the current selection
    assign tile_ok  = !matched_q[key_tile] && !(sel_vld_q && (sel_q == key_tile));

    // Same picture when the low three bits agree, same orientation required
    assign pair_hit = sel_vld_q && !matched_q[sel_q] &&
                      (sel_q[2:0] == key_tile[2:0]) &&
                      (flip_q[sel_q] == flip_q[key_tile]);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            open_q    <= '0;
            matched_q <= '0;
            flip_q    <= memory_game_pkg::INIT_FLIP;
            sel_q     <= '0;
            sel_vld_q <= 1'b0;
            pairs_q   <= '0;
        end else if (reload) begin
            open_q    <= '0;
            matched_q <= '0;
            flip_q    <= memory_game_pkg::INIT_FLIP;
            sel_q     <= '0;
            sel_vld_q <= 1'b0;
            pairs_q   <= '0;
        end else if (apply) begin
            case (event_i.kind)
                memory_game_pkg::KEY_ENTER: begin
                    // matched tiles stay face up
                    open_q    <= open_q & matched_q;
                    sel_vld_q <= 1'b0;
                end
                memory_game_pkg::KEY_SHIFT: begin
                    if (sel_vld_q) begin
                        flip_q[sel_q] <= ~flip_q[sel_q];
                    end
                end
                memory_game_pkg::KEY_TILE: begin
                    if (tile_ok) begin
                        open_q[key_tile] <= 1'b1;
                        if (pair_hit) begin
                            matched_q[key_tile] <= 1'b1;
                            matched_q[sel_q]    <= 1'b1;
                            pairs_q             <= pairs_q + 1'b1;
                        end
                        sel_q     <= key_tile;
                        sel_vld_q <= 1'b1;
                    end
                end
                default: begin
                end
            endcase
        end
    end

    always_comb begin
        for (int i = 0; i < N; i++) begin
            tiles_o[i].open    = open_q[i];
            tiles_o[i].matched = matched_q[i];
            tiles_o[i].flipped = flip_q[i];
        end
    end

    assign pairs_o = pairs_q;

endmodule

/* sim.f */
hw/memory_game_pkg.sv
hw/button_pulse.sv
hw/key_decoder.sv
hw/game_fsm.sv
hw/tile_board.sv
hw/memory_game_top.sv
verification/tb_clock.sv
verification/memory_game_tb.sv

/* verification/memory_game_tb.sv */
`timescale 1ns/1ps

module memory_game_tb;

    localparam int DEB        = 4;
    localparam int WAIT_LIMIT = 20;

    logic                                  clk;
    logic                                  rst;
    logic                                  start_i;
    logic                                  hint_i;
    logic                                  scan_valid_i;
    memory_game_pkg::scan_code_t           scan_code_i;
    memory_game_pkg::game_state_t          state;
    memory_game_pkg::tile_status_t [memory_game_pkg::NUM_TILES-1:0] tiles;
    memory_game_pkg::count_t               pairs;

    logic [memory_game_pkg::NUM_TILES-1:0] exp_open;
    logic [memory_game_pkg::NUM_TILES-1:0] exp_matched;
    logic [memory_game_pkg::NUM_TILES-1:0] exp_flip;
    memory_game_pkg::count_t               exp_pairs;
    integer                                seed;
    int                                    checks;
    int                                    errors;

    tb_clock #(.PERIOD_NS(100), .RESET_CYCLES(4)) u_clock (.clk_o(clk), .rst_o(rst));

    memory_game_top #(.DEBOUNCE_LEN(DEB)) dut (
        .clk         (clk),
        .rst         (rst),
        .start_i     (start_i),
        .hint_i      (hint_i),
        .scan_valid_i(scan_valid_i),
        .scan_code_i (scan_code_i),
        .state_o     (state),
        .tiles_o     (tiles),
        .pairs_o     (pairs)
    );

    task automatic check_state(input memory_game_pkg::game_state_t got,
                               input memory_game_pkg::game_state_t exp);
        checks++;
        if (got !== exp) begin
            $display("error state_o: got %h, expected %h", got, exp);
            errors++;
        end
    endtask

    task automatic check_tile(input int idx, input memory_game_pkg::tile_status_t got,
                              input memory_game_pkg::tile_status_t exp);
        checks++;
        if (got !== exp) begin
            $display("error tiles_o[%0d]: got %h, expected %h", idx, got, exp);
            errors++;
        end
    endtask

    task automatic check_pairs(input memory_game_pkg::count_t got,
                               input memory_game_pkg::count_t exp);
        checks++;
        if (got !== exp) begin
            $display("error pairs_o: got %h, expected %h", got, exp);
            errors++;
        end
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #10;
    endtask

    task automatic init_expect();
        exp_open    = '0;
        exp_matched = '0;
        exp_flip    = memory_game_pkg::INIT_FLIP;
        exp_pairs   = '0;
    endtask

    task automatic check_board();
        memory_game_pkg::tile_status_t exp;
        for (int i = 0; i < memory_game_pkg::NUM_TILES; i++) begin
            exp.open    = exp_open[i];
            exp.matched = exp_matched[i];
            exp.flipped = exp_flip[i];
            check_tile(i, tiles[i], exp);
        end
        check_pairs(pairs, exp_pairs);
    endtask

    task automatic wait_state(input memory_game_pkg::game_state_t want);
        int n;
        n = 0;
        while (state !== want && n < WAIT_LIMIT) begin
            next_cycle();
            n++;
        end
        checks++;
        if (state !== want) begin
            $display("timeout while waiting for state %0d, state is %0d", want, state);
            errors++;
        end
    endtask

    // Hold long enough for the debounce, then release
    task automatic press_start(input memory_game_pkg::game_state_t want);
        start_i = 1'b1;
        repeat (DEB + 2) next_cycle();
        wait_state(want);
        start_i = 1'b0;
        repeat (2) next_cycle();
    endtask

    // Board reflects the code two edges after the strobe edge
    task automatic send_code(input memory_game_pkg::scan_code_t code);
        scan_code_i  = code;
        scan_valid_i = 1'b1;
        next_cycle();
        scan_valid_i = 1'b0;
        scan_code_i  = '0;
        repeat (2) next_cycle();
    endtask

    task automatic press_key(input int idx);
        send_code(memory_game_pkg::TILE_KEY_CODES[idx]);
    endtask

    // Matches every unmatched pair in a shuffled order
    task automatic play_pairs();
        int order[8];
        int n;
        int j;
        int tmp;
        int a;
        n = 0;
        send_code(memory_game_pkg::SC_ENTER);
        for (int t = 0; t < memory_game_pkg::NUM_TILES; t++) begin
            if (!exp_matched[t]) exp_open[t] = 1'b0;
        end
        for (int p = 0; p < memory_game_pkg::NUM_PAIRS; p++) begin
            if (!exp_matched[p]) begin
                order[n] = p;
                n++;
            end
        end
        for (int k = n - 1; k > 0; k--) begin
            j        = $unsigned($random(seed)) % (k + 1);
            tmp      = order[k];
            order[k] = order[j];
            order[j] = tmp;
        end
        for (int k = 0; k < n; k++) begin
            a = order[k];
            press_key(a);
            exp_open[a] = 1'b1;
            if (exp_flip[a] != exp_flip[a + 8]) begin
                send_code(memory_game_pkg::SC_SHIFT);
                exp_flip[a] = ~exp_flip[a];
            end
            press_key(a + 8);
            exp_open[a + 8]    = 1'b1;
            exp_matched[a]     = 1'b1;
            exp_matched[a + 8] = 1'b1;
            exp_pairs++;
            check_board();
        end
    endtask

    task automatic test_reset_start();
        $display("test: reset and start");
        init_expect();
        check_state(state, memory_game_pkg::ST_IDLE);
        check_board();
        // Too short to pass the debounce
        start_i = 1'b1;
        repeat (DEB - 1) next_cycle();
        start_i = 1'b0;
        repeat (DEB + 4) next_cycle();
        check_state(state, memory_game_pkg::ST_IDLE);
        press_start(memory_game_pkg::ST_SHOW);
        press_start(memory_game_pkg::ST_PLAY);
        press_start(memory_game_pkg::ST_PLAY);
        check_board();
    endtask

    task automatic test_match_rule();
        $display("test: match rule");
        press_key(1);
        press_key(9);
        exp_open[1]    = 1'b1;
        exp_open[9]    = 1'b1;
        exp_matched[1] = 1'b1;
        exp_matched[9] = 1'b1;
        exp_pairs      = 4'd1;
        check_board();
        // Tile 0 starts flipped, tile 8 does not
        press_key(0);
        press_key(8);
        exp_open[0] = 1'b1;
        exp_open[8] = 1'b1;
        check_board();
    endtask

    task automatic test_shift_enter();
        $display("test: shift and enter");
        press_key(0);
        send_code(memory_game_pkg::SC_SHIFT);
        exp_flip[0] = ~exp_flip[0];
        check_board();
        press_key(8);
        exp_matched[0] = 1'b1;
        exp_matched[8] = 1'b1;
        exp_pairs      = 4'd2;
        check_board();
        press_key(2);
        exp_open[2] = 1'b1;
        check_board();
        send_code(memory_game_pkg::SC_ENTER);
        exp_open[2] = 1'b0;
        check_board();
    endtask

    task automatic test_hint_ignored();
        $display("test: hint and ignored keys");
        hint_i = 1'b1;
        press_key(3);
        press_key(11);
        check_board();
        hint_i = 1'b0;
        press_key(4);
        exp_open[4] = 1'b1;
        check_board();
        // A second press of the selection must not pair with itself
        press_key(4);
        check_board();
        // Extended flag on top of the code for tile 2
        send_code(9'h000);
        send_code(9'h126);
        check_board();
    endtask

    task automatic test_full_game();
        $display("test: full game");
        play_pairs();
        wait_state(memory_game_pkg::ST_FINISH);
        send_code(memory_game_pkg::SC_SHIFT);
        send_code(memory_game_pkg::SC_ENTER);
        check_board();
        press_start(memory_game_pkg::ST_IDLE);
        init_expect();
        check_board();
        press_start(memory_game_pkg::ST_SHOW);
        press_start(memory_game_pkg::ST_PLAY);
        play_pairs();
        wait_state(memory_game_pkg::ST_FINISH);
        check_board();
    endtask

    initial begin
        #2_000_000;
        $display("simulation did not finish in time");
        $display("tests failed");
        $finish;
    end

    initial begin
        int n;
        start_i      = 1'b0;
        hint_i       = 1'b0;
        scan_valid_i = 1'b0;
        scan_code_i  = '0;
        seed         = 66481;
        checks       = 0;
        errors       = 0;
        n            = 0;
        while (rst !== 1'b0 && n < WAIT_LIMIT) begin
            @(posedge clk);
            n++;
        end
        if (rst !== 1'b0) begin
            $display("reset was never released");
            errors++;
        end
        #10;
        test_reset_start();
        test_match_rule();
        test_shift_enter();
        test_hint_ignored();
        test_full_game();
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

/* verification/tb_clock.sv */
`timescale 1ns/1ps

module tb_clock #(
    parameter int PERIOD_NS    = 100,
    parameter int RESET_CYCLES = 4
) (
    output logic clk_o,
    output logic rst_o
);

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2) clk_o = ~clk_o;
    end

    // Release lines up with the stimulus offset
    initial begin
        rst_o = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk_o);
        #10;
        rst_o = 1'b0;
    end

endmodule
